//--- list.f
+incdir+verif
common/i2c_pkg.sv
logic/bus_cond_detect.sv
logic/i2c_byte_shift.sv
i2c_slave_ctrl/i2c_slave_ctrl.sv
logic/i2c_error_slave.sv
verif/tb_i2c_error_slave.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_i2c_error_slave -o tb_i2c_error_slave \
    && ./obj_dir/tb_i2c_error_slave > sim.log \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^Test passed$" sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

//--- verif/i2c_master_bfm.svh
// I2C bus-master tasks for start, stop, byte write and acknowledge sampling, plus the payload LCG
`ifndef I2C_MASTER_BFM_SVH
`define I2C_MASTER_BFM_SVH

// Next state of the payload generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// One bus bit, set while scl is low; host pulses end here too
task automatic drive_sda(input logic level);
    @(negedge scl);
    sda_drv   = level;
    rx_take   = 1'b0;
    err_clear = 1'b0;
    ack_slot  = 1'b0;
endtask

task automatic idle_cycles(input int count);
    repeat (count) drive_sda(1'b1);
endtask

// sda high through one rising edge, then falls while scl is high
task automatic bus_start();
    drive_sda(1'b1);
    @(posedge scl);
    #2;
    sda_drv = 1'b0;
endtask

// sda low through one rising edge, then rises while scl is high
task automatic bus_stop();
    drive_sda(1'b0);
    @(posedge scl);
    #2;
    sda_drv = 1'b1;
endtask

// MSB first, then sda released for the target's acknowledge
task automatic write_byte(input logic [7:0] value, input logic take, output logic ack);
    int i;
    for (i = 7; i >= 0; i--) begin
        drive_sda(value[i]);
    end
    drive_sda(1'b1);
    rx_take  = take;
    ack_slot = 1'b1;
    // Ninth rising edge
    @(posedge scl);
    ack = !sda_in;
endtask

// Leading bits of a byte that is cut off before it completes
task automatic write_bits(input logic [7:0] value, input int count);
    int i;
    for (i = 0; i < count; i++) begin
        drive_sda(value[7 - i]);
    end
endtask

`endif

//--- verif/tb_i2c_error_slave.sv
// Testbench for the I2C target with clock, reset, open-drain bus, reference model, monitor and watchdog
`timescale 1ns/100ps

module tb_i2c_error_slave;

    logic                           scl;
    logic                           rst_n;
    logic                           sda_drv;
    logic                           sda_in;
    logic [i2c_pkg::addr_width-1:0] device_addr;
    logic                           rx_take;
    logic                           err_clear;
    logic                           sda_pull;
    logic [i2c_pkg::byte_width-1:0] rx_data;
    logic                           rx_valid;
    i2c_pkg::err_flags_t            err;

    // Stimulus and model state of the main process
    logic [31:0]         lcg_state;
    logic [7:0]          payload [0:7];
    logic                ack_slot;
    logic                model_valid;
    i2c_pkg::err_flags_t model_flags;
    logic                exp_ack [0:63];
    logic [7:0]          exp_data [0:63];
    int                  exp_ack_cnt;
    int                  exp_data_cnt;
    int                  check_errors;

    // Written by the monitor
    int   ack_rd;
    int   data_rd;
    logic prev_valid;
    int   monitor_errors;

    // Open-drain bus where either side pulls low
    assign sda_in = sda_drv & ~sda_pull;

    i2c_error_slave dut (
        .scl         (scl),
        .rst_n       (rst_n),
        .sda_in      (sda_in),
        .device_addr (device_addr),
        .rx_take     (rx_take),
        .err_clear   (err_clear),
        .sda_pull    (sda_pull),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .err         (err)
    );

    `include "i2c_master_bfm.svh"

    initial begin
        scl = 1'b0;
        forever #4 scl = ~scl;
    end

    // Slots 0 to 6 carry whole bytes and slot 7 feeds cut-off bits
    task automatic fill_payload();
        int i;
        for (i = 0; i < 8; i++) begin
            lcg_state  = lcg_next(lcg_state);
            payload[i] = lcg_state[23:16];
        end
    endtask

    // Expected acks and stored bytes of one transfer plus the new flags
    function automatic i2c_pkg::err_flags_t predict_transfer(
        input logic [i2c_pkg::addr_width-1:0] addr,
        input logic                           rw,
        input int                             nbytes,
        input int                             cut_bits,
        input logic [7:0]                     take_mask,
        input i2c_pkg::err_flags_t            flags_in
    );
        i2c_pkg::err_flags_t flags;
        logic                going;
        int                  i;
        flags = flags_in;
        going = (addr == device_addr) && !rw;
        if ((addr == device_addr) && rw) begin
            flags.addr = 1'b1;
        end
        exp_ack[exp_ack_cnt] = going;
        exp_ack_cnt = exp_ack_cnt + 1;
        for (i = 0; i < nbytes && going; i++) begin
            if (model_valid) begin
                // Unread byte still held so the new one is dropped and the master stops
                flags.overrun = 1'b1;
                going = 1'b0;
            end else begin
                exp_data[exp_data_cnt] = payload[i];
                exp_data_cnt = exp_data_cnt + 1;
                model_valid = 1'b1;
            end
            exp_ack[exp_ack_cnt] = going;
            exp_ack_cnt = exp_ack_cnt + 1;
            if (take_mask[i]) begin
                model_valid = 1'b0;
            end
        end
        if (going && cut_bits >= 1 && cut_bits <= 7) begin
            flags.framing = 1'b1;
        end
        return flags;
    endfunction

    task automatic run_transfer(
        input logic [i2c_pkg::addr_width-1:0] addr,
        input logic                           rw,
        input int                             nbytes,
        input int                             cut_bits,
        input logic [7:0]                     take_mask,
        input logic                           end_stop
    );
        logic ack;
        int   i;
        fill_payload();
        model_flags = predict_transfer(addr, rw, nbytes, cut_bits, take_mask, model_flags);
        bus_start();
        write_byte({addr, rw}, 1'b0, ack);
        for (i = 0; i < nbytes && ack; i++) begin
            write_byte(payload[i], take_mask[i], ack);
        end
        if (ack) begin
            write_bits(payload[7], cut_bits);
        end
        if (end_stop) begin
            bus_stop();
        end
    endtask

    // One-cycle host pulses on an idle bus
    task automatic host_pulse(input logic take, input logic clear);
        drive_sda(1'b1);
        rx_take   = take;
        err_clear = clear;
        if (take) begin
            model_valid = 1'b0;
        end
        if (clear) begin
            model_flags = '0;
        end
        drive_sda(1'b1);
    endtask

    task automatic check_outcome();
        idle_cycles(2);
        if (err !== model_flags) begin
            $display("FAIL err: got %h, expected %h", err, model_flags);
            check_errors++;
        end
        if (rx_valid !== model_valid) begin
            $display("FAIL rx_valid: got %h, expected %h", rx_valid, model_valid);
            check_errors++;
        end
        if (model_valid && rx_data !== exp_data[exp_data_cnt - 1]) begin
            $display("FAIL rx_data: got %h, expected %h", rx_data, exp_data[exp_data_cnt - 1]);
            check_errors++;
        end
        if (ack_rd != exp_ack_cnt) begin
            $display("Acknowledge slots missed: %0d expected, %0d seen", exp_ack_cnt, ack_rd);
            check_errors++;
        end
        if (data_rd != exp_data_cnt) begin
            $display("Received bytes missed: %0d expected, %0d seen", exp_data_cnt, data_rd);
            check_errors++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        sda_drv      = 1'b1;
        device_addr  = 7'h3c;
        rx_take      = 1'b0;
        err_clear    = 1'b0;
        ack_slot     = 1'b0;
        lcg_state    = 32'ha1f7;
        model_valid  = 1'b0;
        model_flags  = '0;
        exp_ack_cnt  = 0;
        exp_data_cnt = 0;
        check_errors = 0;
        repeat (10) @(posedge scl);
        @(negedge scl);
        rst_n = 1'b1;
        idle_cycles(2);
        if (sda_pull !== 1'b0 || rx_valid !== 1'b0 || err !== 3'h0) begin
            $display("FAIL reset: sda_pull %h, rx_valid %h, err %h", sda_pull, rx_valid, err);
            check_errors++;
        end

        // Matching write with each byte taken in its ack slot
        run_transfer(device_addr, 1'b0, 4, 0, 8'h0f, 1'b1);
        check_outcome();
        // Foreign address
        run_transfer(device_addr ^ 7'h11, 1'b0, 2, 0, 8'h03, 1'b1);
        check_outcome();
        // Read request followed by a normal write
        run_transfer(device_addr, 1'b1, 0, 0, 8'h00, 1'b1);
        check_outcome();
        run_transfer(device_addr, 1'b0, 2, 0, 8'h03, 1'b1);
        check_outcome();
        // Host never takes so the second byte overruns
        run_transfer(device_addr, 1'b0, 2, 0, 8'h00, 1'b1);
        check_outcome();
        host_pulse(1'b1, 1'b0);
        check_outcome();
        // Stop after four bits
        run_transfer(device_addr, 1'b0, 0, 4, 8'h00, 1'b1);
        check_outcome();
        // All three flags cleared so the restart raises framing on its own
        host_pulse(1'b0, 1'b1);
        check_outcome();
        // Restart after three bits followed by a normal write
        run_transfer(device_addr, 1'b0, 0, 3, 8'h00, 1'b0);
        run_transfer(device_addr, 1'b0, 1, 0, 8'h01, 1'b1);
        check_outcome();
        // Clear everything and run one clean transfer
        host_pulse(1'b0, 1'b1);
        check_outcome();
        run_transfer(device_addr, 1'b0, 3, 0, 8'h07, 1'b1);
        check_outcome();

        $display("Errors: %0d from the monitor, %0d from end checks", monitor_errors, check_errors);
        if (monitor_errors == 0 && check_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Ack slots checked at rising scl and new held bytes at falling scl
    initial begin
        monitor_errors = 0;
        ack_rd         = 0;
        data_rd        = 0;
        prev_valid     = 1'b0;
        forever begin
            @(posedge scl);
            if (ack_slot) begin
                if (ack_rd >= exp_ack_cnt) begin
                    $display("Acknowledge slot seen with no transfer expecting one");
                    monitor_errors++;
                end else begin
                    if ((!sda_in) !== exp_ack[ack_rd]) begin
                        $display("FAIL ack: got %h, expected %h", !sda_in, exp_ack[ack_rd]);
                        monitor_errors++;
                    end
                    ack_rd++;
                end
            end else if (sda_pull) begin
                $display("Target pulled sda outside an acknowledge slot");
                monitor_errors++;
            end
            @(negedge scl);
            if (rx_valid && !prev_valid) begin
                if (data_rd >= exp_data_cnt) begin
                    $display("rx_valid rose with no byte expected");
                    monitor_errors++;
                end else begin
                    if (rx_data !== exp_data[data_rd]) begin
                        $display("FAIL rx_data: got %h, expected %h", rx_data, exp_data[data_rd]);
                        monitor_errors++;
                    end
                    data_rd++;
                end
            end
            prev_valid = rx_valid;
        end
    end

    // Twice the bus time of all transfers, checks and host pulses
    initial begin
        int budget_cycles;
        budget_cycles = 12 + 9 * (4 + 9 * 5 + 8 + 4) + 3 * 4 + 11 * 2;
        #(budget_cycles * 8 * 2);
        $display("Watchdog expired before the tests completed");
        $display("Errors: %0d from the monitor, %0d from end checks", monitor_errors, check_errors);
        $display("Test failed");
        $finish;
    end

endmodule

//--- logic/i2c_error_slave.sv
// Top level of the receive-only I2C target: condition detector, shifter and controller
`timescale 1ns/100ps

module i2c_error_slave (
    input  logic                           scl,
    input  logic                           rst_n,
    input  logic                           sda_in,
    input  logic [i2c_pkg::addr_width-1:0] device_addr,
    input  logic                           rx_take,
    input  logic                           err_clear,
    output logic                           sda_pull,
    output logic [i2c_pkg::byte_width-1:0] rx_data,
    output logic                           rx_valid,
    output i2c_pkg::err_flags_t            err
);

    i2c_pkg::bus_cond_t cond;
    i2c_pkg::i2c_byte_u shift_byte;
    logic [3:0]         bit_cnt;
    logic               byte_done;
    logic               shift_clear;

    // Start and stop seen between rising scl edges
    bus_cond_detect u_cond (
        .scl    (scl),
        .sda_in (sda_in),
        .rst_n  (rst_n),
        .cond   (cond)
    );

    // Bit collection
    i2c_byte_shift u_shift (
        .scl         (scl),
        .rst_n       (rst_n),
        .sda_in      (sda_in),
        .cond        (cond),
        .shift_clear (shift_clear),
        .shift_byte  (shift_byte),
        .bit_cnt     (bit_cnt),
        .byte_done   (byte_done)
    );

    // Protocol, acknowledge and host side
    i2c_slave_ctrl u_ctrl (
        .scl         (scl),
        .rst_n       (rst_n),
        .device_addr (device_addr),
        .cond        (cond),
        .shift_byte  (shift_byte),
        .bit_cnt     (bit_cnt),
        .byte_done   (byte_done),
        .rx_take     (rx_take),
        .err_clear   (err_clear),
        .shift_clear (shift_clear),
        .sda_pull    (sda_pull),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .err         (err)
    );

endmodule

//--- i2c_slave_ctrl/i2c_slave_ctrl.sv
// Transfer FSM with address check, acknowledge drive, receive holding register and error flags
`timescale 1ns/100ps

module i2c_slave_ctrl (
    input  logic                             scl,
    input  logic                             rst_n,
    input  logic [i2c_pkg::addr_width-1:0]   device_addr,
    input  i2c_pkg::bus_cond_t               cond,
    input  i2c_pkg::i2c_byte_u               shift_byte,
    input  logic [3:0]                       bit_cnt,
    input  logic                             byte_done,
    input  logic                             rx_take,
    input  logic                             err_clear,
    output logic                             shift_clear,
    output logic                             sda_pull,
    output logic [i2c_pkg::byte_width-1:0]   rx_data,
    output logic                             rx_valid,
    output i2c_pkg::err_flags_t              err
);

    i2c_pkg::ctrl_state_e state;
    i2c_pkg::ctrl_state_e state_nxt;

    logic                byte_end;
    logic                addr_hit;
    logic                addr_ok;
    logic                addr_read;
    logic                data_store;
    logic                data_lost;
    logic                frame_break;
    logic                ack_req;
    i2c_pkg::err_flags_t err_new;

    // A byte that completes together with a stop is not a byte
    assign byte_end = byte_done && !cond.stop;

    // First byte after a start, read through the address view
    assign addr_hit  = (shift_byte.addr_view.addr == device_addr);
    assign addr_ok   = (state == i2c_pkg::addr) && byte_end && addr_hit &&
                       !shift_byte.addr_view.rw;
    // Reads are not supported, a read to our address is an error
    assign addr_read = (state == i2c_pkg::addr) && byte_end && addr_hit &&
                       shift_byte.addr_view.rw;

    // Payload byte, kept only if the host has taken the previous one
    assign data_store = (state == i2c_pkg::data) && byte_end && (!rx_valid || rx_take);
    assign data_lost  = (state == i2c_pkg::data) && byte_end && rx_valid && !rx_take;

    // The edge before a condition always samples its setup level,
    // so a clean stop or restart arrives with a count of one.
    // Higher counts mean real data bits were cut off
    assign frame_break = (state == i2c_pkg::data) && (cond.start || cond.stop) &&
                         (bit_cnt > 4'd1) && (bit_cnt < 4'(i2c_pkg::byte_width));

    // Shifter is held while nothing is expected or the ack slot is running
    always_comb begin
        case (state)
            i2c_pkg::addr,
            i2c_pkg::data: shift_clear = 1'b0;
            default:       shift_clear = 1'b1;
        endcase
    end

    // Bus conditions override whatever the FSM is doing
    always_comb begin
        state_nxt = state;
        if (cond.stop) begin
            state_nxt = i2c_pkg::idle;
        end else if (cond.start) begin
            state_nxt = i2c_pkg::addr;
        end else begin
            case (state)
                i2c_pkg::addr: begin
                    if (byte_done) begin
                        state_nxt = addr_ok ? i2c_pkg::addr_ack : i2c_pkg::ignore;
                    end
                end
                i2c_pkg::addr_ack: state_nxt = i2c_pkg::data;
                i2c_pkg::data: begin
                    // An overrun byte still has its ack slot, left undriven
                    if (byte_done) begin
                        state_nxt = i2c_pkg::data_ack;
                    end
                end
                i2c_pkg::data_ack: state_nxt = i2c_pkg::data;
                default:           state_nxt = state;
            endcase
        end
    end

    always_ff @(posedge scl or negedge rst_n) begin
        if (!rst_n) begin
            state <= i2c_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Ack decided on the eighth rising edge, high for one scl period
    always_ff @(posedge scl or negedge rst_n) begin
        if (!rst_n) begin
            ack_req <= 1'b0;
        end else begin
            ack_req <= addr_ok || data_store;
        end
    end

    // Driven from the falling edge so sda only moves while scl is low
    always_ff @(negedge scl or negedge rst_n) begin
        if (!rst_n) begin
            sda_pull <= 1'b0;
        end else begin
            sda_pull <= ack_req;
        end
    end

    // Holding register
    always_ff @(posedge scl) begin
        if (data_store) begin
            rx_data <= shift_byte.data_view;
        end
    end

    // A new byte beats a take on the same edge
    always_ff @(posedge scl or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else if (data_store) begin
            rx_valid <= 1'b1;
        end else if (rx_take) begin
            rx_valid <= 1'b0;
        end
    end

    always_comb begin
        err_new.framing = frame_break;
        err_new.overrun = data_lost;
        err_new.addr    = addr_read;
    end

    // Sticky flags, a clear never hides an error raised on the same edge
    always_ff @(posedge scl or negedge rst_n) begin
        if (!rst_n) begin
            err <= '0;
        end else if (err_clear) begin
            err <= err_new;
        end else begin
            err.framing <= err.framing || err_new.framing;
            err.overrun <= err.overrun || err_new.overrun;
            err.addr    <= err.addr || err_new.addr;
        end
    end

endmodule

//--- logic/i2c_byte_shift.sv
// Serial-in shift register with bit counter and byte completion strobe
`timescale 1ns/100ps

module i2c_byte_shift (
    input  logic               scl,
    input  logic               rst_n,
    input  logic               sda_in,
    input  i2c_pkg::bus_cond_t cond,
    input  logic               shift_clear,
    output i2c_pkg::i2c_byte_u shift_byte,
    output logic [3:0]         bit_cnt,
    output logic               byte_done
);

    // The seven bits taken before the current edge
    logic [i2c_pkg::byte_width-2:0] shift_reg;

    // Current sda level joins as LSB, so the full byte is already visible
    // at the edge that samples its last bit
    assign shift_byte = i2c_pkg::i2c_byte_u'({shift_reg, sda_in});

    // Eighth bit on this edge, unless the count is being restarted
    always_comb begin
        byte_done = 1'b0;
        if (!cond.start && !shift_clear) begin
            byte_done = (bit_cnt == 4'(i2c_pkg::byte_width - 1));
        end
    end

    // MSB first, older bits fall off the top
    always_ff @(posedge scl) begin
        shift_reg <= shift_byte.data_view[i2c_pkg::byte_width-2:0];
    end

    // Bits taken since the last start or byte boundary
    always_ff @(posedge scl or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= 4'd0;
        end else if (cond.start) begin
            // The edge that sees the start already carries the first address bit
            bit_cnt <= 4'd1;
        end else if (shift_clear) begin
            // Acknowledge slot or inactive state, nothing counted
            bit_cnt <= 4'd0;
        end else if (bit_cnt != 4'(i2c_pkg::byte_width)) begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

endmodule

//--- logic/bus_cond_detect.sv
// Start and stop condition detector, sda-edge flags handed to the scl domain
`timescale 1ns/100ps

module bus_cond_detect (
    input  logic               scl,
    input  logic               sda_in,
    input  logic               rst_n,
    output i2c_pkg::bus_cond_t cond
);

    // Each condition flips a toggle in the sda domain
    // The scl side keeps a copy, a difference means one condition is pending
    logic start_tog;
    logic stop_tog;
    logic start_seen;
    logic stop_seen;

    // Falling sda while scl is high is a start
    always_ff @(negedge sda_in or negedge rst_n) begin
        if (!rst_n) begin
            start_tog <= 1'b0;
        end else if (scl) begin
            start_tog <= ~start_tog;
        end
    end

    // Rising sda while scl is high is a stop
    always_ff @(posedge sda_in or negedge rst_n) begin
        if (!rst_n) begin
            stop_tog <= 1'b0;
        end else if (scl) begin
            stop_tog <= ~stop_tog;
        end
    end

    // The rising scl edge that samples a condition also retires it,
    // so each one is seen by exactly one edge
    always_ff @(posedge scl or negedge rst_n) begin
        if (!rst_n) begin
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end else begin
            start_seen <= start_tog;
            stop_seen  <= stop_tog;
        end
    end

    always_comb begin
        cond.start = start_tog ^ start_seen;
        cond.stop  = stop_tog ^ stop_seen;
    end

endmodule

//--- common/i2c_pkg.sv
// I2C target package: bus widths, controller states, received byte union, error and condition structs
package i2c_pkg;

    // Target address width in bits
    localparam int addr_width = 7;

    // Data bits per transfer
    localparam int byte_width = 8;

    // Controller states
    // idle      bus free or after a stop
    // addr      collecting the address byte
    // addr_ack  acknowledge slot of the address byte
    // data      collecting a payload byte
    // data_ack  acknowledge slot of a payload byte
    // ignore    transfer not for us, wait for the next start or stop
    typedef enum logic [2:0] {
        idle     = 3'd0,
        addr     = 3'd1,
        addr_ack = 3'd2,
        data     = 3'd3,
        data_ack = 3'd4,
        ignore   = 3'd5
    } ctrl_state_e;

    // First byte after a start, address in the upper seven bits
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic                  rw;
    } addr_view_t;

    // One received byte
    // Read as address plus direction right after a start, as payload otherwise
    typedef union packed {
        addr_view_t            addr_view;
        logic [byte_width-1:0] data_view;
    } i2c_byte_u;

    // Sticky error flags seen by the host
    typedef struct packed {
        // Start or stop in the middle of a payload byte
        logic framing;
        // Payload byte arrived while the previous one was still unread
        logic overrun;
        // Read request to our own address
        logic addr;
    } err_flags_t;

    // Bus conditions caught since the previous rising scl
    typedef struct packed {
        logic start;
        logic stop;
    } bus_cond_t;

endpackage
